/* processor_core.f */
verilog/cotm32_pkg.sv
verilog/cotm32_priv_pkg.sv
verilog/inst_fetch.sv
verilog/register_file.sv
verilog/exec_unit.sv
verilog/cu.sv
verilog/lsu.sv
verilog/trap_unit.sv
verilog/csr_file.sv
verilog/processor_core.sv
verif/processor_core_assertions.sv
verif/processor_core_tb.sv

/* Bender.yml */
package:
  name: processor_core

sources:
  - verilog/cotm32_pkg.sv
  - verilog/cotm32_priv_pkg.sv
  - verilog/inst_fetch.sv
  - verilog/register_file.sv
  - verilog/exec_unit.sv
  - verilog/cu.sv
  - verilog/lsu.sv
  - verilog/trap_unit.sv
  - verilog/csr_file.sv
  - verilog/processor_core.sv
  - target: test
    files:
      - verif/processor_core_assertions.sv
      - verif/processor_core_tb.sv

/* verif/processor_core_tb.sv */
`timescale 1ns/100ps

module processor_core_tb;

  localparam int IMEM_WORDS = 128;
  localparam int DMEM_WORDS = 64;
  localparam int MAX_ROWS = 160;
  localparam logic [31:0] HANDLER = 32'h0000_0180;
  localparam logic [31:0] RESULT_ADDR = 32'h0000_0080;

  // One cycle of the expected trace
  typedef struct packed {
    logic [2:0] test;
    logic [31:0] inst;
    logic [31:0] pc;
    logic we;
    logic [3:0] strb;
    logic [31:0] addr;
    logic [31:0] data;
  } row_t;

  logic clk;
  logic rst;
  cotm32_pkg::word_t imem_addr;
  cotm32_pkg::inst_t imem_inst;
  cotm32_pkg::word_t dmem_addr;
  logic dmem_we;
  cotm32_pkg::wstrb_t dmem_wstrb;
  cotm32_pkg::word_t dmem_wdata;
  cotm32_pkg::word_t dmem_rdata;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  row_t rows [MAX_ROWS];
  string test_name [8];
  logic [31:0] xr [32];
  logic [31:0] bpc;
  logic [15:0] lfsr;
  logic [2:0] cur_test;
  int n_rows;
  int n_tests;
  int cur_row;
  int checks;
  int errors;
  int test_errs;
  int test_rows;

  processor_core dut_i (
    .i_clk(clk),
    .i_rst(rst),
    .o_imem_addr(imem_addr),
    .i_imem_inst(imem_inst),
    .o_dmem_addr(dmem_addr),
    .o_dmem_we(dmem_we),
    .o_dmem_wstrb(dmem_wstrb),
    .o_dmem_wdata(dmem_wdata),
    .i_dmem_rdata(dmem_rdata)
  );

  always #2 clk = ~clk;

  assign imem_inst = imem[imem_addr[8:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    if (dmem_we === 1'b1) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  // Fibonacci taps x16 x14 x13 x11 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("ERROR at %0t ns: row %0d %s expected %08h, got %08h",
               $time, cur_row, what, exp, got);
    end
  endtask

  task automatic add_row(input logic [31:0] inst, input logic [31:0] next_pc,
                         input logic we, input logic [3:0] strb,
                         input logic [31:0] addr, input logic [31:0] data);
    rows[n_rows].test = cur_test;
    rows[n_rows].inst = inst;
    rows[n_rows].pc = bpc;
    rows[n_rows].we = we;
    rows[n_rows].strb = strb;
    rows[n_rows].addr = addr;
    rows[n_rows].data = data;
    n_rows++;
    bpc = next_pc;
  endtask

  task automatic emit(input logic [31:0] inst);
    add_row(inst, bpc + 4, 1'b0, 4'b0000, '0, '0);
  endtask

  task automatic redirect(input logic [31:0] inst, input logic [31:0] target);
    add_row(inst, target, 1'b0, 4'b0000, '0, '0);
  endtask

  task automatic expect_store(input logic [31:0] inst, input logic [3:0] strb,
                              input logic [31:0] addr, input logic [31:0] data);
    add_row(inst, bpc + 4, 1'b1, strb, addr, data);
  endtask

  // Result goes out through SW to the fixed result word
  task automatic write_result(input logic [31:0] inst, input logic [4:0] rd,
                              input logic [31:0] value);
    xr[rd] = value;
    emit(inst);
    expect_store(stype(RESULT_ADDR[11:0], rd, 5'd0, 3'b010), 4'b1111, RESULT_ADDR, value);
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                        input logic taken);
    if (taken) begin
      redirect(btype(13'd8, rs2, rs1, f3), bpc + 8);
    end else begin
      emit(btype(13'd8, rs2, rs1, f3));
    end
  endtask

  // Handler reports mcause and mepc, then resumes after the trapping word
  task automatic run_handler(input logic [31:0] cause, input logic [31:0] epc);
    write_result(itype(12'h342, 5'd0, 3'b010, 5'd21, 7'h73), 5'd21, cause);
    write_result(itype(12'h341, 5'd0, 3'b010, 5'd22, 7'h73), 5'd22, epc);
    emit(itype(12'h004, 5'd22, 3'b000, 5'd22, 7'h13));
    emit(itype(12'h341, 5'd22, 3'b001, 5'd0, 7'h73));
    redirect(32'h3020_0073, epc + 4);
  endtask

  task automatic take_trap(input logic [31:0] inst, input logic [31:0] cause);
    logic [31:0] epc;
    epc = bpc;
    redirect(inst, HANDLER);
    run_handler(cause, epc);
  endtask

  task automatic start_test(input string name);
    cur_test = n_tests;
    test_name[n_tests] = name;
    n_tests++;
  endtask

  task automatic build_program();
    logic [31:0] ia;
    logic [31:0] ib;
    logic [31:0] ic;
    logic [31:0] link;
    logic [7:0] lanes [4];
    logic [1:0] lane;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i << 7) | 32'h7f;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
    end
    lfsr = 16'd48231;
    bpc = '0;

    start_test("arithmetic");
    for (int p = 0; p < 2; p++) begin
      ia = lfsr_bits(12);
      ib = lfsr_bits(12);
      xr[1] = sext12(ia[11:0]);
      emit(itype(ia[11:0], 5'd0, 3'b000, 5'd1, 7'h13));
      write_result(itype(ib[11:0], 5'd1, 3'b000, 5'd2, 7'h13), 5'd2, xr[1] + sext12(ib[11:0]));
    end
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, xr[1] + xr[2]);
    write_result(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, xr[1] - xr[2]);
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 5'd3, xr[1] & xr[2]);
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 5'd3, xr[1] | xr[2]);
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 5'd3, xr[1] ^ xr[2]);
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 5'd3,
                 {31'b0, $signed(xr[1]) < $signed(xr[2])});
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), 5'd3, xr[1] << xr[2][4:0]);
    write_result(rtype(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3, xr[1] >> xr[2][4:0]);
    write_result(rtype(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3, $signed(xr[1]) >>> xr[2][4:0]);
    ic = lfsr_bits(12);
    write_result(itype(ic[11:0], 5'd2, 3'b111, 5'd4, 7'h13), 5'd4, xr[2] & sext12(ic[11:0]));
    write_result(itype(ic[11:0], 5'd2, 3'b110, 5'd4, 7'h13), 5'd4, xr[2] | sext12(ic[11:0]));
    write_result(itype(ic[11:0], 5'd2, 3'b100, 5'd4, 7'h13), 5'd4, xr[2] ^ sext12(ic[11:0]));
    write_result(itype(ic[11:0], 5'd2, 3'b010, 5'd4, 7'h13), 5'd4,
                 {31'b0, $signed(xr[2]) < $signed(sext12(ic[11:0]))});
    write_result(utype(20'habcde, 5'd8, 7'h37), 5'd8, 32'habcd_e000);
    write_result(utype(20'h12345, 5'd9, 7'h17), 5'd9, bpc + 32'h1234_5000);

    start_test("control flow");
    emit(itype(12'd5, 5'd0, 3'b000, 5'd10, 7'h13));
    emit(itype(12'hffd, 5'd0, 3'b000, 5'd11, 7'h13));
    // x10 = 5, x11 = -3
    branch(3'b000, 5'd10, 5'd10, 1'b1);
    branch(3'b000, 5'd10, 5'd11, 1'b0);
    branch(3'b001, 5'd10, 5'd11, 1'b1);
    branch(3'b001, 5'd10, 5'd10, 1'b0);
    branch(3'b100, 5'd11, 5'd10, 1'b1);
    branch(3'b100, 5'd10, 5'd11, 1'b0);
    branch(3'b101, 5'd10, 5'd11, 1'b1);
    branch(3'b101, 5'd11, 5'd10, 1'b0);
    link = bpc + 4;
    redirect(jtype(21'd12, 5'd12), bpc + 12);
    expect_store(stype(RESULT_ADDR[11:0], 5'd12, 5'd0, 3'b010), 4'b1111, RESULT_ADDR, link);
    xr[13] = bpc;
    emit(utype(20'h0, 5'd13, 7'h17));
    link = bpc + 4;
    // Odd offset so bit 0 of the target is dropped
    redirect(itype(12'd17, 5'd13, 3'b000, 5'd14, 7'h67), (xr[13] + 32'd17) & ~32'd1);
    expect_store(stype(RESULT_ADDR[11:0], 5'd14, 5'd0, 3'b010), 4'b1111, RESULT_ADDR, link);

    start_test("bytes");
    for (int k = 0; k < 4; k++) begin
      lane = k;
      lanes[lane] = 8'h81 + 8'h22 * lane;
      emit(itype({4'h0, lanes[lane]}, 5'd0, 3'b000, 5'd15, 7'h13));
      expect_store(stype(12'h090 + lane, 5'd15, 5'd0, 3'b000), 4'b0001 << lane,
                   32'h90 + lane, {4{lanes[lane]}});
    end
    write_result(itype(12'h092, 5'd0, 3'b100, 5'd16, 7'h03), 5'd16, {24'b0, lanes[2]});
    write_result(itype(12'h090, 5'd0, 3'b010, 5'd17, 7'h03), 5'd17,
                 {lanes[3], lanes[2], lanes[1], lanes[0]});

    start_test("traps");
    emit(itype(HANDLER[11:0], 5'd0, 3'b000, 5'd20, 7'h13));
    emit(itype(12'h305, 5'd20, 3'b001, 5'd0, 7'h73));
    take_trap(32'h0000_0073, 32'd11);

    start_test("faults");
    take_trap(stype(12'h082, 5'd0, 5'd0, 3'b010), 32'd6);
    take_trap(32'hffff_ffff, 32'd2);
    take_trap(32'h3020_0073, 32'd2);
    emit(itype(12'h05c, 5'd0, 3'b000, 5'd23, 7'h13));
    emit(itype(12'h340, 5'd23, 3'b001, 5'd0, 7'h73));
    emit(itype(12'h300, 5'd0, 3'b000, 5'd24, 7'h13));
    write_result(itype(12'h340, 5'd24, 3'b010, 5'd25, 7'h73), 5'd25, 32'h0000_005c);
    write_result(itype(12'h340, 5'd0, 3'b010, 5'd26, 7'h73), 5'd26, 32'h0000_035c);

    // Program words come from the trace table
    for (int r = 0; r < n_rows; r++) begin
      imem[rows[r].pc[8:2]] = rows[r].inst;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    n_rows = 0;
    n_tests = 0;
    checks = 0;
    errors = 0;
    test_errs = 0;
    test_rows = 0;
    build_program();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      if (r > 0) begin
        @(negedge clk);
      end
      cur_row = r;
      check("pc", imem_addr, rows[r].pc);
      check("store enable", dmem_we, rows[r].we);
      check("byte strobe", dmem_wstrb, rows[r].strb);
      if (rows[r].we) begin
        check("store address", dmem_addr, rows[r].addr);
        check("store data", dmem_wdata, rows[r].data);
      end
      test_rows++;
      if ((r == n_rows - 1) || (rows[r + 1].test != rows[r].test)) begin
        $display("test %0d %s: %0d cycles, %0d errors",
                 rows[r].test, test_name[rows[r].test], test_rows, test_errs);
        test_rows = 0;
        test_errs = 0;
      end
    end
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut_i.assertions_i.fails);
    if ((errors == 0) && (dut_i.assertions_i.fails == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Trace length plus reset and some slack
  initial begin
    #1;
    #((n_rows + 24) * 4);
    $display("Watchdog expired: trace did not finish within %0d cycles", n_rows + 24);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verif/processor_core_assertions.sv */
`timescale 1ns/100ps

module processor_core_assertions (
  input logic               i_clk,
  input logic               i_rst,
  input cotm32_pkg::word_t  i_imem_addr,
  input logic               i_dmem_we,
  input cotm32_pkg::wstrb_t i_dmem_wstrb
);

  int fails = 0;

  // A store always names at least one byte
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_dmem_we |-> (i_dmem_wstrb != 4'b0000))
    else begin
      fails++;
      $error("store issued with an empty byte strobe");
    end

  // First reset edge still sees the PC from before reset
  assert property (@(posedge i_clk) (i_rst && $past(i_rst)) |-> !i_dmem_we)
    else begin
      fails++;
      $error("data write enabled during reset");
    end

  assert property (@(posedge i_clk) disable iff (i_rst) i_imem_addr[1:0] == 2'b00)
    else begin
      fails++;
      $error("instruction fetch address not word aligned");
    end

endmodule

bind processor_core processor_core_assertions assertions_i (
  .i_clk(i_clk),
  .i_rst(i_rst),
  .i_imem_addr(o_imem_addr),
  .i_dmem_we(o_dmem_we),
  .i_dmem_wstrb(o_dmem_wstrb)
);

/* verilog/processor_core.sv */
`timescale 1ns/100ps

module processor_core (
  input  logic               i_clk,
  input  logic               i_rst,
  output cotm32_pkg::word_t  o_imem_addr,
  input  cotm32_pkg::inst_t  i_imem_inst,
  output cotm32_pkg::word_t  o_dmem_addr,
  output logic               o_dmem_we,
  output cotm32_pkg::wstrb_t o_dmem_wstrb,
  output cotm32_pkg::word_t  o_dmem_wdata,
  input  cotm32_pkg::word_t  i_dmem_rdata
);

  cotm32_pkg::word_t pc;
  cotm32_pkg::word_t pc_4;
  cotm32_pkg::ctrl_t ctrl;
  cotm32_pkg::word_t imm;
  cotm32_pkg::word_t rs1;
  cotm32_pkg::word_t rs2;
  cotm32_pkg::word_t alu_a;
  cotm32_pkg::word_t alu_b;
  cotm32_pkg::word_t alu_out;
  cotm32_pkg::word_t lsu_rdata;
  cotm32_pkg::word_t reg_wb;
  logic take;
  logic reg_we;

  cotm32_priv_pkg::csr_addr_t csr_addr;
  cotm32_priv_pkg::csr_op_t csr_op;
  cotm32_pkg::word_t csr_rdata;
  cotm32_pkg::word_t csr_mtvec;
  cotm32_pkg::word_t csr_mepc;
  logic csr_use_csr_wb;

  cotm32_priv_pkg::trap_t trap;
  logic trap_mode;
  logic cu_illegal;
  logic csr_illegal;
  logic illegal;
  logic ecall;
  logic mret;
  logic load_misaligned;
  logic store_misaligned;

  // Unknown CSR only matters for an actual CSR instruction
  assign illegal = cu_illegal | (csr_use_csr_wb & csr_illegal);

  assign alu_a = (ctrl.alu_a_sel == cotm32_pkg::ALU_A_PC) ? pc : rs1;
  assign alu_b = (ctrl.alu_b_sel == cotm32_pkg::ALU_B_IMM) ? imm : rs2;

  always_comb begin
    case (ctrl.reg_wb_sel)
      cotm32_pkg::REG_WB_PC4: reg_wb = pc_4;
      cotm32_pkg::REG_WB_LSU: reg_wb = lsu_rdata;
      cotm32_pkg::REG_WB_CSR: reg_wb = csr_rdata;
      default: reg_wb = alu_out;
    endcase
  end

  assign reg_we = ctrl.reg_we & ~trap.req;
  assign o_imem_addr = pc;
  assign o_dmem_addr = alu_out;

  inst_fetch ifu (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_take(take),
    .i_target(alu_out),
    .i_trap(trap),
    .i_mret(mret),
    .i_mtvec(csr_mtvec),
    .i_mepc(csr_mepc),
    .o_pc(pc),
    .o_pc_4(pc_4)
  );

  cu cu (
    .i_inst(i_imem_inst),
    .i_trap_mode(trap_mode),
    .o_ctrl(ctrl),
    .o_imm(imm),
    .o_csr_addr(csr_addr),
    .o_csr_op(csr_op),
    .o_csr_use_csr_wb(csr_use_csr_wb),
    .o_illegal(cu_illegal),
    .o_ecall(ecall),
    .o_mret(mret)
  );

  register_file rf (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_we(reg_we),
    .i_waddr(ctrl.rd),
    .i_raddr1(ctrl.rs1),
    .i_raddr2(ctrl.rs2),
    .i_wdata(reg_wb),
    .o_rdata1(rs1),
    .o_rdata2(rs2)
  );

  exec_unit eu (
    .i_a(alu_a),
    .i_b(alu_b),
    .i_rs1(rs1),
    .i_rs2(rs2),
    .i_alu_op(ctrl.alu_op),
    .i_bu_op(ctrl.bu_op),
    .o_alu(alu_out),
    .o_take(take)
  );

  lsu lsu (
    .i_op(ctrl.lsu_op),
    .i_addr(alu_out),
    .i_wdata(rs2),
    .i_rdata(i_dmem_rdata),
    .i_trap_req(trap.req),
    .o_we(o_dmem_we),
    .o_wstrb(o_dmem_wstrb),
    .o_wdata(o_dmem_wdata),
    .o_rdata(lsu_rdata),
    .o_load_misaligned(load_misaligned),
    .o_store_misaligned(store_misaligned)
  );

  trap_unit tu (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_pc(pc),
    .i_illegal(illegal),
    .i_ecall(ecall),
    .i_load_misaligned(load_misaligned),
    .i_store_misaligned(store_misaligned),
    .i_mret(mret),
    .o_trap(trap),
    .o_trap_mode(trap_mode)
  );

  csr_file csr (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_op(csr_op),
    .i_addr(csr_addr),
    .i_wdata(rs1),
    .i_trap(trap),
    .o_rdata(csr_rdata),
    .o_mtvec(csr_mtvec),
    .o_mepc(csr_mepc),
    .o_illegal(csr_illegal)
  );

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/100ps

module csr_file (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  cotm32_priv_pkg::csr_op_t   i_op,
  input  cotm32_priv_pkg::csr_addr_t i_addr,
  input  cotm32_pkg::word_t          i_wdata,
  input  cotm32_priv_pkg::trap_t     i_trap,
  output cotm32_pkg::word_t          o_rdata,
  output cotm32_pkg::word_t          o_mtvec,
  output cotm32_pkg::word_t          o_mepc,
  output logic                       o_illegal
);

  cotm32_pkg::word_t mtvec;
  cotm32_pkg::word_t mepc;
  cotm32_pkg::word_t mcause;
  cotm32_pkg::word_t mscratch;
  cotm32_pkg::word_t wval;

  always_comb begin
    o_illegal = 1'b0;
    case (i_addr)
      cotm32_priv_pkg::CSR_MTVEC: o_rdata = mtvec;
      cotm32_priv_pkg::CSR_MEPC: o_rdata = mepc;
      cotm32_priv_pkg::CSR_MCAUSE: o_rdata = mcause;
      cotm32_priv_pkg::CSR_MSCRATCH: o_rdata = mscratch;
      default: begin
        o_rdata = '0;
        o_illegal = 1'b1;
      end
    endcase
  end

  assign wval = (i_op == cotm32_priv_pkg::CSR_OP_SET) ? (o_rdata | i_wdata) : i_wdata;

  // mtvec is direct mode only and mepc is word aligned, so the low bits stay zero
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
      mscratch <= '0;
    end else if (i_trap.req) begin
      mepc <= {i_trap.epc[cotm32_pkg::XLEN-1:2], 2'b00};
      mcause <= i_trap.cause;
    end else if (i_op != cotm32_priv_pkg::CSR_OP_NONE) begin
      case (i_addr)
        cotm32_priv_pkg::CSR_MTVEC: mtvec <= {wval[cotm32_pkg::XLEN-1:2], 2'b00};
        cotm32_priv_pkg::CSR_MEPC: mepc <= {wval[cotm32_pkg::XLEN-1:2], 2'b00};
        cotm32_priv_pkg::CSR_MCAUSE: mcause <= wval;
        cotm32_priv_pkg::CSR_MSCRATCH: mscratch <= wval;
        default: ;
      endcase
    end
  end

  assign o_mtvec = mtvec;
  assign o_mepc = mepc;

endmodule

/* verilog/trap_unit.sv */
`timescale 1ns/100ps

module trap_unit (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  cotm32_pkg::word_t      i_pc,
  input  logic                   i_illegal,
  input  logic                   i_ecall,
  input  logic                   i_load_misaligned,
  input  logic                   i_store_misaligned,
  input  logic                   i_mret,
  output cotm32_priv_pkg::trap_t o_trap,
  output logic                   o_trap_mode
);

  logic trap_mode;

  always_comb begin
    o_trap.req = i_illegal | i_ecall | i_load_misaligned | i_store_misaligned;
    o_trap.epc = i_pc;
    if (i_illegal) begin
      o_trap.cause = cotm32_priv_pkg::CAUSE_ILLEGAL_INST;
    end else if (i_ecall) begin
      o_trap.cause = cotm32_priv_pkg::CAUSE_ECALL_M;
    end else if (i_load_misaligned) begin
      o_trap.cause = cotm32_priv_pkg::CAUSE_LOAD_MISALIGNED;
    end else begin
      o_trap.cause = cotm32_priv_pkg::CAUSE_STORE_MISALIGNED;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      trap_mode <= 1'b0;
    end else if (o_trap.req) begin
      trap_mode <= 1'b1;
    end else if (i_mret) begin
      trap_mode <= 1'b0;
    end
  end

  assign o_trap_mode = trap_mode;

endmodule

/* verilog/lsu.sv */
`timescale 1ns/100ps

module lsu (
  input  cotm32_pkg::lsu_op_t i_op,
  input  cotm32_pkg::word_t   i_addr,
  input  cotm32_pkg::word_t   i_wdata,
  input  cotm32_pkg::word_t   i_rdata,
  input  logic                i_trap_req,
  output logic                o_we,
  output cotm32_pkg::wstrb_t  o_wstrb,
  output cotm32_pkg::word_t   o_wdata,
  output cotm32_pkg::word_t   o_rdata,
  output logic                o_load_misaligned,
  output logic                o_store_misaligned
);

  logic [1:0] offset;
  logic store;
  cotm32_pkg::wstrb_t strb;

  assign offset = i_addr[1:0];

  always_comb begin
    store = 1'b0;
    strb = '0;
    o_wdata = i_wdata;
    case (i_op)
      cotm32_pkg::LSU_SW: begin
        store = 1'b1;
        strb = 4'b1111;
      end
      cotm32_pkg::LSU_SB: begin
        store = 1'b1;
        strb = 4'b0001 << offset;
        o_wdata = {4{i_wdata[7:0]}};
      end
      default: ;
    endcase
  end

  assign o_load_misaligned = (i_op == cotm32_pkg::LSU_LW) && (offset != 2'b00);
  assign o_store_misaligned = (i_op == cotm32_pkg::LSU_SW) && (offset != 2'b00);

  // Trapped stores leave memory untouched
  assign o_we = store & ~i_trap_req;
  assign o_wstrb = i_trap_req ? '0 : strb;

  assign o_rdata = (i_op == cotm32_pkg::LSU_LBU) ? {24'b0, i_rdata[8*offset +: 8]} : i_rdata;

endmodule

/* verilog/cu.sv */
`timescale 1ns/100ps

module cu (
  input  cotm32_pkg::inst_t          i_inst,
  input  logic                       i_trap_mode,
  output cotm32_pkg::ctrl_t          o_ctrl,
  output cotm32_pkg::word_t          o_imm,
  output cotm32_priv_pkg::csr_addr_t o_csr_addr,
  output cotm32_priv_pkg::csr_op_t   o_csr_op,
  output logic                       o_csr_use_csr_wb,
  output logic                       o_illegal,
  output logic                       o_ecall,
  output logic                       o_mret
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  cotm32_pkg::word_t imm_i;
  cotm32_pkg::word_t imm_s;
  cotm32_pkg::word_t imm_b;
  cotm32_pkg::word_t imm_u;
  cotm32_pkg::word_t imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_csr_addr = i_inst[31:20];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl = '0;
    o_ctrl.rd = i_inst[11:7];
    o_ctrl.rs1 = i_inst[19:15];
    o_ctrl.rs2 = i_inst[24:20];
    o_imm = imm_i;
    o_csr_op = cotm32_priv_pkg::CSR_OP_NONE;
    o_csr_use_csr_wb = 1'b0;
    o_illegal = 1'b0;
    o_ecall = 1'b0;
    o_mret = 1'b0;

    case (opcode)
      cotm32_pkg::OP_LUI: begin
        o_ctrl.alu_op = cotm32_pkg::ALU_PASS_B;
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_ctrl.reg_we = 1'b1;
        o_imm = imm_u;
      end
      cotm32_pkg::OP_AUIPC: begin
        o_ctrl.alu_a_sel = cotm32_pkg::ALU_A_PC;
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_ctrl.reg_we = 1'b1;
        o_imm = imm_u;
      end
      cotm32_pkg::OP_JAL: begin
        o_ctrl.alu_a_sel = cotm32_pkg::ALU_A_PC;
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_ctrl.bu_op = cotm32_pkg::BU_JUMP;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.reg_wb_sel = cotm32_pkg::REG_WB_PC4;
        o_imm = imm_j;
      end
      cotm32_pkg::OP_JALR: begin
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_ctrl.bu_op = cotm32_pkg::BU_JUMP;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.reg_wb_sel = cotm32_pkg::REG_WB_PC4;
        o_illegal = (funct3 != 3'b000);
      end
      cotm32_pkg::OP_BRANCH: begin
        // Target comes from the ALU as PC + imm
        o_ctrl.alu_a_sel = cotm32_pkg::ALU_A_PC;
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_imm = imm_b;
        case (funct3)
          3'b000: o_ctrl.bu_op = cotm32_pkg::BU_EQ;
          3'b001: o_ctrl.bu_op = cotm32_pkg::BU_NE;
          3'b100: o_ctrl.bu_op = cotm32_pkg::BU_LT;
          3'b101: o_ctrl.bu_op = cotm32_pkg::BU_GE;
          default: o_illegal = 1'b1;
        endcase
      end
      cotm32_pkg::OP_LOAD: begin
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_ctrl.reg_we = 1'b1;
        o_ctrl.reg_wb_sel = cotm32_pkg::REG_WB_LSU;
        case (funct3)
          3'b010: o_ctrl.lsu_op = cotm32_pkg::LSU_LW;
          3'b100: o_ctrl.lsu_op = cotm32_pkg::LSU_LBU;
          default: o_illegal = 1'b1;
        endcase
      end
      cotm32_pkg::OP_STORE: begin
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_imm = imm_s;
        case (funct3)
          3'b010: o_ctrl.lsu_op = cotm32_pkg::LSU_SW;
          3'b000: o_ctrl.lsu_op = cotm32_pkg::LSU_SB;
          default: o_illegal = 1'b1;
        endcase
      end
      cotm32_pkg::OP_IMM: begin
        o_ctrl.alu_b_sel = cotm32_pkg::ALU_B_IMM;
        o_ctrl.reg_we = 1'b1;
        case (funct3)
          3'b000: o_ctrl.alu_op = cotm32_pkg::ALU_ADD;
          3'b010: o_ctrl.alu_op = cotm32_pkg::ALU_SLT;
          3'b100: o_ctrl.alu_op = cotm32_pkg::ALU_XOR;
          3'b110: o_ctrl.alu_op = cotm32_pkg::ALU_OR;
          3'b111: o_ctrl.alu_op = cotm32_pkg::ALU_AND;
          default: o_illegal = 1'b1;
        endcase
      end
      cotm32_pkg::OP_REG: begin
        o_ctrl.reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_ctrl.alu_op = cotm32_pkg::ALU_ADD;
          10'b0100000_000: o_ctrl.alu_op = cotm32_pkg::ALU_SUB;
          10'b0000000_001: o_ctrl.alu_op = cotm32_pkg::ALU_SLL;
          10'b0000000_010: o_ctrl.alu_op = cotm32_pkg::ALU_SLT;
          10'b0000000_100: o_ctrl.alu_op = cotm32_pkg::ALU_XOR;
          10'b0000000_101: o_ctrl.alu_op = cotm32_pkg::ALU_SRL;
          10'b0100000_101: o_ctrl.alu_op = cotm32_pkg::ALU_SRA;
          10'b0000000_110: o_ctrl.alu_op = cotm32_pkg::ALU_OR;
          10'b0000000_111: o_ctrl.alu_op = cotm32_pkg::ALU_AND;
          default: o_illegal = 1'b1;
        endcase
      end
      cotm32_pkg::OP_SYSTEM: begin
        if (i_inst == cotm32_priv_pkg::INST_ECALL) begin
          o_ecall = 1'b1;
        end else if (i_inst == cotm32_priv_pkg::INST_MRET) begin
          // Only legal while a trap is being handled
          o_mret = i_trap_mode;
          o_illegal = !i_trap_mode;
        end else begin
          o_ctrl.reg_we = 1'b1;
          o_ctrl.reg_wb_sel = cotm32_pkg::REG_WB_CSR;
          o_csr_use_csr_wb = 1'b1;
          case (funct3)
            3'b001: o_csr_op = cotm32_priv_pkg::CSR_OP_WRITE;
            3'b010: o_csr_op = cotm32_priv_pkg::CSR_OP_SET;
            default: o_illegal = 1'b1;
          endcase
        end
      end
      default: o_illegal = 1'b1;
    endcase
  end

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
  input  cotm32_pkg::word_t   i_a,
  input  cotm32_pkg::word_t   i_b,
  input  cotm32_pkg::word_t   i_rs1,
  input  cotm32_pkg::word_t   i_rs2,
  input  cotm32_pkg::alu_op_t i_alu_op,
  input  cotm32_pkg::bu_op_t  i_bu_op,
  output cotm32_pkg::word_t   o_alu,
  output logic                o_take
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_alu_op)
      cotm32_pkg::ALU_ADD: o_alu = i_a + i_b;
      cotm32_pkg::ALU_SUB: o_alu = i_a - i_b;
      cotm32_pkg::ALU_AND: o_alu = i_a & i_b;
      cotm32_pkg::ALU_OR: o_alu = i_a | i_b;
      cotm32_pkg::ALU_XOR: o_alu = i_a ^ i_b;
      cotm32_pkg::ALU_SLT: o_alu = {{(cotm32_pkg::XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      cotm32_pkg::ALU_SLL: o_alu = i_a << shamt;
      cotm32_pkg::ALU_SRL: o_alu = i_a >> shamt;
      cotm32_pkg::ALU_SRA: o_alu = $signed(i_a) >>> shamt;
      cotm32_pkg::ALU_PASS_B: o_alu = i_b;
      default: o_alu = '0;
    endcase
  end

  // Branch decision, independent of the ALU path
  always_comb begin
    case (i_bu_op)
      cotm32_pkg::BU_EQ: o_take = (i_rs1 == i_rs2);
      cotm32_pkg::BU_NE: o_take = (i_rs1 != i_rs2);
      cotm32_pkg::BU_LT: o_take = ($signed(i_rs1) < $signed(i_rs2));
      cotm32_pkg::BU_GE: o_take = ($signed(i_rs1) >= $signed(i_rs2));
      cotm32_pkg::BU_JUMP: o_take = 1'b1;
      default: o_take = 1'b0;
    endcase
  end

endmodule

/* verilog/register_file.sv */
`timescale 1ns/100ps

module register_file (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_we,
  input  cotm32_pkg::reg_addr_t i_waddr,
  input  cotm32_pkg::reg_addr_t i_raddr1,
  input  cotm32_pkg::reg_addr_t i_raddr2,
  input  cotm32_pkg::word_t     i_wdata,
  output cotm32_pkg::word_t     o_rdata1,
  output cotm32_pkg::word_t     o_rdata2
);

  // x0 has no storage
  cotm32_pkg::word_t regs [1:cotm32_pkg::NUM_REGS-1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < cotm32_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* verilog/inst_fetch.sv */
`timescale 1ns/100ps

module inst_fetch (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_take,
  input  cotm32_pkg::word_t           i_target,
  input  cotm32_priv_pkg::trap_t      i_trap,
  input  logic                        i_mret,
  input  cotm32_pkg::word_t           i_mtvec,
  input  cotm32_pkg::word_t           i_mepc,
  output cotm32_pkg::word_t           o_pc,
  output cotm32_pkg::word_t           o_pc_4
);

  cotm32_pkg::word_t pc;
  cotm32_pkg::word_t pc_next;

  assign o_pc = pc;
  assign o_pc_4 = pc + 32'd4;

  // Trap wins over MRET, MRET over branches
  always_comb begin
    if (i_trap.req) begin
      pc_next = i_mtvec;
    end else if (i_mret) begin
      pc_next = i_mepc;
    end else if (i_take) begin
      pc_next = {i_target[cotm32_pkg::XLEN-1:1], 1'b0};
    end else begin
      pc_next = o_pc_4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= cotm32_pkg::RESET_VECTOR;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* verilog/cotm32_priv_pkg.sv */
package cotm32_priv_pkg;

  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t CSR_MTVEC = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC = 12'h341;
  localparam csr_addr_t CSR_MCAUSE = 12'h342;

  // Full encodings of the two privileged instructions kept
  localparam cotm32_pkg::inst_t INST_ECALL = 32'h0000_0073;
  localparam cotm32_pkg::inst_t INST_MRET = 32'h3020_0073;

  typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET} csr_op_t;

  typedef enum logic [31:0] {
    CAUSE_ILLEGAL_INST = 32'd2,
    CAUSE_LOAD_MISALIGNED = 32'd4,
    CAUSE_STORE_MISALIGNED = 32'd6,
    CAUSE_ECALL_M = 32'd11
  } trap_cause_t;

  typedef struct packed {
    logic req;
    trap_cause_t cause;
    cotm32_pkg::word_t epc;
  } trap_t;

endpackage

/* verilog/cotm32_pkg.sv */
package cotm32_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;
  localparam logic [XLEN-1:0] RESET_VECTOR = '0;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [XLEN/8-1:0] wstrb_t;

  // Major opcodes
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic {ALU_A_RS1, ALU_A_PC} alu_a_sel_t;
  typedef enum logic {ALU_B_RS2, ALU_B_IMM} alu_b_sel_t;

  typedef enum logic [2:0] {BU_NONE, BU_EQ, BU_NE, BU_LT, BU_GE, BU_JUMP} bu_op_t;
  typedef enum logic [2:0] {LSU_NONE, LSU_LW, LSU_LBU, LSU_SW, LSU_SB} lsu_op_t;
  typedef enum logic [1:0] {REG_WB_ALU, REG_WB_PC4, REG_WB_LSU, REG_WB_CSR} reg_wb_sel_t;

  typedef struct packed {
    alu_op_t alu_op;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    bu_op_t bu_op;
    lsu_op_t lsu_op;
    logic reg_we;
    reg_wb_sel_t reg_wb_sel;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
  } ctrl_t;

endpackage
